/* src/core_pkg.sv */
// Widths are fixed by the 32-bit instruction format and are not meant to be overridden
package core_pkg;

    ////////////////////////////////////////
    // Datapath and storage sizes
    ////////////////////////////////////////

    localparam int data_width = 16;
    localparam int reg_addr_width = 3;
    localparam int max_channels = 4;
    localparam int channel_width = 2;
    localparam int store_depth = 64;
    localparam int pc_width = 6;
    localparam int instr_width = 32;

    // Cycles from the last valid issue to its register write
    localparam int pipeline_drain = 3;

    ////////////////////////////////////////
    // Instruction field layout
    ////////////////////////////////////////

    localparam int opcode_msb = 31;
    localparam int opcode_lsb = 28;
    localparam int dest_msb = 27;
    localparam int dest_lsb = 25;
    localparam int src_a_msb = 24;
    localparam int src_a_lsb = 22;
    localparam int src_b_msb = 21;
    localparam int src_b_lsb = 19;
    // Bits 18 to 16 are reserved
    localparam int imm_msb = 15;
    localparam int imm_lsb = 0;

    // Codes above op_stop are illegal
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_shl  = 4'd6,
        op_addi = 4'd7,
        op_ldi  = 4'd8,
        op_chan = 4'd9,
        op_stop = 4'd10
    } opcode_t;

    typedef enum logic [1:0] {
        idle,
        fetch,
        drain
    } ctrl_state_t;

endpackage

/* src/core_if.sv */
// Single-cycle valid strobes only, with no ready and no back-pressure on either bus
interface issue_if;
    logic valid;
    core_pkg::opcode_t opcode;
    logic [core_pkg::channel_width-1:0] channel;
    logic [core_pkg::reg_addr_width-1:0] dest;
    logic [core_pkg::reg_addr_width-1:0] src_a;
    logic [core_pkg::reg_addr_width-1:0] src_b;
    logic [core_pkg::data_width-1:0] immediate;

    modport master (output valid, opcode, channel, dest, src_a, src_b, immediate);
    modport monitor (input valid, opcode, channel, dest, src_a, src_b, immediate);
endinterface

// Writeback bus, one register write per valid cycle
interface result_if;
    logic valid;
    logic [core_pkg::channel_width-1:0] channel;
    logic [core_pkg::reg_addr_width-1:0] dest;
    logic [core_pkg::data_width-1:0] data;

    modport source (output valid, channel, dest, data);
    modport sink (input valid, channel, dest, data);
endinterface

/* src/instruction_store.sv */
// Program memory has no reset and must not be written while the core is busy
module instruction_store (
    input  logic clock,
    input  logic prog_write,
    input  logic [core_pkg::pc_width-1:0] prog_addr,
    input  logic [core_pkg::instr_width-1:0] prog_data,
    input  logic fetch_enable,
    input  logic [core_pkg::pc_width-1:0] fetch_addr,
    output logic [core_pkg::instr_width-1:0] fetch_data
);

    logic [core_pkg::instr_width-1:0] mem [core_pkg::store_depth];

    // Host load port
    always_ff @(posedge clock) begin
        if (prog_write) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Word is returned one cycle after the fetch
    always_ff @(posedge clock) begin
        if (fetch_enable) begin
            fetch_data <= mem[fetch_addr];
        end
    end

endmodule

/* src/control_unit.sv */
// No hazard interlock, so programs must space dependent instructions by four words
module control_unit (
    input  logic clock,
    input  logic arst_n,
    input  logic run,
    input  logic [2:0] n_channels,
    input  logic [core_pkg::instr_width-1:0] fetch_data,
    input  logic illegal,
    output logic fetch_enable,
    output logic [core_pkg::pc_width-1:0] fetch_addr,
    output logic instr_valid,
    output logic [core_pkg::instr_width-1:0] instr_word,
    output logic [core_pkg::channel_width-1:0] instr_channel,
    output logic busy,
    output logic done,
    output logic fault
);

    core_pkg::ctrl_state_t state;
    logic [core_pkg::pc_width-1:0] pc;
    logic [core_pkg::channel_width-1:0] channel;
    logic [core_pkg::channel_width-1:0] last_channel;
    logic [core_pkg::channel_width-1:0] fetch_channel;
    logic fetch_pending;
    logic stop_hit;
    logic error_seen;
    logic [1:0] drain_count;

    // Returned word is a stop while still fetching
    assign stop_hit = fetch_pending && (state == core_pkg::fetch) &&
        (fetch_data[core_pkg::opcode_msb:core_pkg::opcode_lsb] == core_pkg::op_stop);

    assign fetch_enable = (state == core_pkg::fetch) && !stop_hit && !illegal;
    assign fetch_addr = pc;

    // The word in flight behind a stop or an illegal opcode is dropped here
    assign instr_valid = fetch_pending && (state == core_pkg::fetch) && !illegal;
    assign instr_word = fetch_data;
    assign instr_channel = fetch_channel;

    assign busy = (state != core_pkg::idle) || done;
    assign fault = error_seen && (state == core_pkg::idle);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= core_pkg::idle;
            pc <= '0;
            channel <= '0;
            last_channel <= '0;
            fetch_pending <= 1'b0;
            error_seen <= 1'b0;
            drain_count <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            fetch_pending <= fetch_enable;
            case (state)
                core_pkg::idle: begin
                    if (run) begin
                        state <= core_pkg::fetch;
                        pc <= '0;
                        channel <= '0;
                        error_seen <= 1'b0;
                        // Zero runs one channel, anything above the maximum is clamped
                        if (n_channels == 3'd0) begin
                            last_channel <= '0;
                        end else if (n_channels >= core_pkg::max_channels) begin
                            last_channel <= '1;
                        end else begin
                            last_channel <= n_channels[core_pkg::channel_width-1:0] - 1'b1;
                        end
                    end
                end
                core_pkg::fetch: begin
                    if (illegal || stop_hit) begin
                        state <= core_pkg::drain;
                        drain_count <= '0;
                        error_seen <= illegal;
                    end else if (channel == last_channel) begin
                        channel <= '0;
                        pc <= pc + 1'b1;
                    end else begin
                        channel <= channel + 1'b1;
                    end
                end
                core_pkg::drain: begin
                    if (drain_count == core_pkg::pipeline_drain - 1) begin
                        state <= core_pkg::idle;
                        done <= 1'b1;
                    end else begin
                        drain_count <= drain_count + 1'b1;
                    end
                end
                default: state <= core_pkg::idle;
            endcase
        end
    end

    // Channel tag follows its word through the store latency
    always_ff @(posedge clock) begin
        if (fetch_enable) begin
            fetch_channel <= channel;
        end
    end

endmodule

/* src/instruction_decoder.sv */
// Nop and stop produce no issue, undefined opcodes produce a one-cycle illegal strobe
module instruction_decoder (
    input  logic clock,
    input  logic arst_n,
    input  logic instr_valid,
    input  logic [core_pkg::instr_width-1:0] instr_word,
    input  logic [core_pkg::channel_width-1:0] instr_channel,
    issue_if.master issue,
    output logic illegal
);

    core_pkg::opcode_t opcode;
    logic is_operation;
    logic is_known;

    assign opcode = core_pkg::opcode_t'(instr_word[core_pkg::opcode_msb:core_pkg::opcode_lsb]);

    // Opcode classification
    always_comb begin
        is_operation = 1'b0;
        is_known = 1'b1;
        case (opcode)
            core_pkg::op_nop, core_pkg::op_stop: begin
                is_operation = 1'b0;
            end
            core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and, core_pkg::op_or,
            core_pkg::op_xor, core_pkg::op_shl, core_pkg::op_addi, core_pkg::op_ldi,
            core_pkg::op_chan: begin
                is_operation = 1'b1;
            end
            default: begin
                is_known = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            issue.valid <= 1'b0;
            illegal <= 1'b0;
        end else begin
            issue.valid <= instr_valid && is_operation;
            illegal <= instr_valid && !is_known;
        end
    end

    // Operation fields
    always_ff @(posedge clock) begin
        issue.opcode <= opcode;
        issue.channel <= instr_channel;
        issue.dest <= instr_word[core_pkg::dest_msb:core_pkg::dest_lsb];
        issue.src_a <= instr_word[core_pkg::src_a_msb:core_pkg::src_a_lsb];
        issue.src_b <= instr_word[core_pkg::src_b_msb:core_pkg::src_b_lsb];
        issue.immediate <= instr_word[core_pkg::imm_msb:core_pkg::imm_lsb];
    end

endmodule

/* src/register_file.sv */
// Reads in the same cycle as a write to that register return the new value
module register_file (
    input  logic clock,
    input  logic arst_n,
    issue_if.monitor issue,
    result_if.sink result,
    output logic [core_pkg::data_width-1:0] operand_a,
    output logic [core_pkg::data_width-1:0] operand_b,
    input  logic host_read,
    input  logic [core_pkg::channel_width-1:0] host_channel,
    input  logic [core_pkg::reg_addr_width-1:0] host_addr,
    output logic [core_pkg::data_width-1:0] host_data,
    output logic host_data_valid
);

    logic [core_pkg::data_width-1:0] regs [core_pkg::max_channels][1 << core_pkg::reg_addr_width];

    // Array read with write-first bypass from the result bus
    function automatic logic [core_pkg::data_width-1:0] read_word(
        input logic [core_pkg::channel_width-1:0] ch,
        input logic [core_pkg::reg_addr_width-1:0] addr
    );
        if (result.valid && (result.channel == ch) && (result.dest == addr)) begin
            return result.data;
        end
        return regs[ch][addr];
    endfunction

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < core_pkg::max_channels; c++) begin
                for (int r = 0; r < (1 << core_pkg::reg_addr_width); r++) begin
                    regs[c][r] <= '0;
                end
            end
            host_data_valid <= 1'b0;
        end else begin
            if (result.valid) begin
                regs[result.channel][result.dest] <= result.data;
            end
            host_data_valid <= host_read;
        end
    end

    // Operand ports line up with the operation registered in the execution unit
    always_ff @(posedge clock) begin
        operand_a <= read_word(issue.channel, issue.src_a);
        operand_b <= read_word(issue.channel, issue.src_b);
        if (host_read) begin
            host_data <= read_word(host_channel, host_addr);
        end
    end

endmodule

/* src/execution_unit.sv */
// All arithmetic wraps modulo 2 to the 16th, with no flags or overflow detection
module execution_unit (
    input  logic clock,
    input  logic arst_n,
    issue_if.monitor issue,
    input  logic [core_pkg::data_width-1:0] operand_a,
    input  logic [core_pkg::data_width-1:0] operand_b,
    result_if.source result
);

    logic op_valid;
    core_pkg::opcode_t op_code;
    logic [core_pkg::channel_width-1:0] op_channel;
    logic [core_pkg::reg_addr_width-1:0] op_dest;
    logic [core_pkg::data_width-1:0] op_imm;
    logic [core_pkg::data_width-1:0] alu_out;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            op_valid <= 1'b0;
            result.valid <= 1'b0;
        end else begin
            op_valid <= issue.valid;
            result.valid <= op_valid;
        end
    end

    ////////////////////////////////////////
    // Operation and result registers
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        op_code <= issue.opcode;
        op_channel <= issue.channel;
        op_dest <= issue.dest;
        op_imm <= issue.immediate;
        result.channel <= op_channel;
        result.dest <= op_dest;
        result.data <= alu_out;
    end

    always_comb begin
        case (op_code)
            core_pkg::op_add:  alu_out = operand_a + operand_b;
            core_pkg::op_sub:  alu_out = operand_a - operand_b;
            core_pkg::op_and:  alu_out = operand_a & operand_b;
            core_pkg::op_or:   alu_out = operand_a | operand_b;
            core_pkg::op_xor:  alu_out = operand_a ^ operand_b;
            // Shift amount is the low nibble of the immediate
            core_pkg::op_shl:  alu_out = operand_a << op_imm[3:0];
            core_pkg::op_addi: alu_out = operand_a + op_imm;
            core_pkg::op_ldi:  alu_out = op_imm;
            core_pkg::op_chan: begin
                alu_out = {{(core_pkg::data_width - core_pkg::channel_width){1'b0}}, op_channel};
            end
            default:           alu_out = '0;
        endcase
    end

endmodule

/* src/channel_core.sv */
// Host must wait for done before loading a new program or reading results
module channel_core (
    input  logic clock,
    input  logic arst_n,
    input  logic prog_write,
    input  logic [core_pkg::pc_width-1:0] prog_addr,
    input  logic [core_pkg::instr_width-1:0] prog_data,
    input  logic run,
    input  logic [2:0] n_channels,
    output logic busy,
    output logic done,
    output logic fault,
    input  logic host_read,
    input  logic [core_pkg::channel_width-1:0] host_channel,
    input  logic [core_pkg::reg_addr_width-1:0] host_addr,
    output logic [core_pkg::data_width-1:0] host_data,
    output logic host_data_valid
);

    issue_if issue ();
    result_if result ();

    logic fetch_enable;
    logic [core_pkg::pc_width-1:0] fetch_addr;
    logic [core_pkg::instr_width-1:0] fetch_data;
    logic instr_valid;
    logic [core_pkg::instr_width-1:0] instr_word;
    logic [core_pkg::channel_width-1:0] instr_channel;
    logic illegal;
    logic [core_pkg::data_width-1:0] operand_a;
    logic [core_pkg::data_width-1:0] operand_b;

    ////////////////////////////////////////
    // Fetch and sequencing
    ////////////////////////////////////////

    instruction_store store_i (
        .clock(clock),
        .prog_write(prog_write),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .fetch_enable(fetch_enable),
        .fetch_addr(fetch_addr),
        .fetch_data(fetch_data)
    );

    control_unit control_i (
        .clock(clock),
        .arst_n(arst_n),
        .run(run),
        .n_channels(n_channels),
        .fetch_data(fetch_data),
        .illegal(illegal),
        .fetch_enable(fetch_enable),
        .fetch_addr(fetch_addr),
        .instr_valid(instr_valid),
        .instr_word(instr_word),
        .instr_channel(instr_channel),
        .busy(busy),
        .done(done),
        .fault(fault)
    );

    ////////////////////////////////////////
    // Decode, operands and execute
    ////////////////////////////////////////

    instruction_decoder decoder_i (
        .clock(clock),
        .arst_n(arst_n),
        .instr_valid(instr_valid),
        .instr_word(instr_word),
        .instr_channel(instr_channel),
        .issue(issue.master),
        .illegal(illegal)
    );

    register_file registers_i (
        .clock(clock),
        .arst_n(arst_n),
        .issue(issue.monitor),
        .result(result.sink),
        .operand_a(operand_a),
        .operand_b(operand_b),
        .host_read(host_read),
        .host_channel(host_channel),
        .host_addr(host_addr),
        .host_data(host_data),
        .host_data_valid(host_data_valid)
    );

    execution_unit execute_i (
        .clock(clock),
        .arst_n(arst_n),
        .issue(issue.monitor),
        .operand_a(operand_a),
        .operand_b(operand_b),
        .result(result.source)
    );

endmodule

/* testbench/clock_gen.sv */
// Free-running clock with a period of 4 time units, reset held low for the first 3 rising edges
module clock_gen (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clock);
        arst_n <= 1'b1;
    end

endmodule

/* testbench/channel_core_tb.sv */
// Generated programs keep dependent words four apart, since the core has no hazard interlock
module channel_core_tb;

    localparam int max_words = 16;
    localparam int run_count = 11;
    localparam int run_cycles = max_words * 4 + 20;
    localparam int host_cycles = max_words + 2 * 32 + 10;
    localparam int watchdog_cycles = (run_count + 1) * (run_cycles + host_cycles);

    logic clock;
    logic arst_n;
    logic prog_write;
    logic [core_pkg::pc_width-1:0] prog_addr;
    logic [core_pkg::instr_width-1:0] prog_data;
    logic run;
    logic [2:0] n_channels;
    logic busy;
    logic done;
    logic fault;
    logic host_read;
    logic [core_pkg::channel_width-1:0] host_channel;
    logic [core_pkg::reg_addr_width-1:0] host_addr;
    logic [core_pkg::data_width-1:0] host_data;
    logic host_data_valid;

    logic [31:0] rng_state;
    logic [31:0] prog [$];
    logic [15:0] model_regs [4][8];
    logic model_fault;
    int runs_started;
    int done_pulses;

    clock_gen clock_gen_i (
        .clock(clock),
        .arst_n(arst_n)
    );

    channel_core dut_i (
        .clock(clock),
        .arst_n(arst_n),
        .prog_write(prog_write),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .run(run),
        .n_channels(n_channels),
        .busy(busy),
        .done(done),
        .fault(fault),
        .host_read(host_read),
        .host_channel(host_channel),
        .host_addr(host_addr),
        .host_data(host_data),
        .host_data_valid(host_data_valid)
    );

    task automatic stop_with(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string what);
        stop_with($sformatf("mismatch at %0t: %s", $time, what));
    endtask

    ////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////

    host_valid_timing: assert property (@(posedge clock) disable iff (!arst_n)
        host_data_valid == $past(host_read))
        else report_mismatch("host_data_valid is not exactly one cycle after host_read");
    done_single_cycle: assert property (@(posedge clock) disable iff (!arst_n)
        done |=> !done)
        else report_mismatch("done held for more than one cycle");
    busy_after_run: assert property (@(posedge clock) disable iff (!arst_n)
        (run && !busy) |=> busy)
        else report_mismatch("busy did not rise the cycle after run");
    busy_until_done: assert property (@(posedge clock) disable iff (!arst_n)
        (busy && !done) |=> busy)
        else report_mismatch("busy fell before done");
    busy_with_done: assert property (@(posedge clock) disable iff (!arst_n)
        done |-> busy)
        else report_mismatch("busy low in the done cycle");
    busy_ends: assert property (@(posedge clock) disable iff (!arst_n)
        (done && !run) |=> !busy)
        else report_mismatch("busy still high after done");
    idle_stays: assert property (@(posedge clock) disable iff (!arst_n)
        (!busy && !run) |=> !busy)
        else report_mismatch("busy rose without a run");
    fault_when_idle: assert property (@(posedge clock) disable iff (!arst_n)
        fault |-> (!busy || done))
        else report_mismatch("fault high during a run");

    always @(posedge clock) begin
        if (arst_n && done) begin
            done_pulses <= done_pulses + 1;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        stop_with($sformatf("timeout: the tests did not finish within %0d cycles",
            watchdog_cycles));
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Opcode, dest, source a, source b, three unused bits, immediate
    function automatic logic [31:0] encode(input logic [3:0] op, input logic [2:0] dest,
                                           input logic [2:0] a, input logic [2:0] b,
                                           input logic [15:0] imm);
        return {op, dest, a, b, 3'b000, imm};
    endfunction

    task automatic pad(input int count);
        repeat (count) prog.push_back(encode(core_pkg::op_nop, 3'd0, 3'd0, 3'd0, 16'h0));
    endtask

    task automatic build_alu_program();
        prog.delete();
        prog.push_back(encode(core_pkg::op_ldi, 3'd1, 3'd0, 3'd0, 16'(next_random())));
        prog.push_back(encode(core_pkg::op_ldi, 3'd2, 3'd0, 3'd0, 16'(next_random())));
        pad(3);
        prog.push_back(encode(core_pkg::op_add, 3'd3, 3'd1, 3'd2, 16'h0));
        prog.push_back(encode(core_pkg::op_sub, 3'd4, 3'd1, 3'd2, 16'h0));
        prog.push_back(encode(core_pkg::op_and, 3'd5, 3'd1, 3'd2, 16'h0));
        prog.push_back(encode(core_pkg::op_or, 3'd6, 3'd1, 3'd2, 16'h0));
        prog.push_back(encode(core_pkg::op_xor, 3'd7, 3'd1, 3'd2, 16'h0));
        prog.push_back(encode(core_pkg::op_shl, 3'd0, 3'd1, 3'd0, 16'(next_random())));
        prog.push_back(encode(core_pkg::op_addi, 3'd2, 3'd1, 3'd0, 16'(next_random())));
        pad(2);
        // Final add chains the add and sub results back through the register file
        prog.push_back(encode(core_pkg::op_add, 3'd1, 3'd3, 3'd4, 16'h0));
        prog.push_back(encode(core_pkg::op_stop, 3'd0, 3'd0, 3'd0, 16'h0));
    endtask

    task automatic build_channel_program();
        prog.delete();
        prog.push_back(encode(core_pkg::op_chan, 3'd0, 3'd0, 3'd0, 16'h0));
        prog.push_back(encode(core_pkg::op_ldi, 3'd1, 3'd0, 3'd0, 16'(next_random())));
        prog.push_back(encode(core_pkg::op_ldi, 3'd2, 3'd0, 3'd0, 16'(next_random())));
        pad(3);
        prog.push_back(encode(core_pkg::op_add, 3'd3, 3'd0, 3'd1, 16'h0));
        prog.push_back(encode(core_pkg::op_xor, 3'd4, 3'd0, 3'd2, 16'h0));
        prog.push_back(encode(core_pkg::op_shl, 3'd5, 3'd2, 3'd0, 16'(next_random())));
        prog.push_back(encode(core_pkg::op_sub, 3'd6, 3'd2, 3'd0, 16'h0));
        prog.push_back(encode(core_pkg::op_addi, 3'd7, 3'd0, 3'd0, 16'(next_random())));
        pad(2);
        prog.push_back(encode(core_pkg::op_add, 3'd1, 3'd3, 3'd4, 16'h0));
        prog.push_back(encode(core_pkg::op_stop, 3'd0, 3'd0, 3'd0, 16'h0));
    endtask

    task automatic build_fault_program();
        prog.delete();
        prog.push_back(encode(core_pkg::op_chan, 3'd0, 3'd0, 3'd0, 16'h0));
        prog.push_back(encode(core_pkg::op_ldi, 3'd1, 3'd0, 3'd0, 16'(next_random())));
        prog.push_back(encode(core_pkg::op_ldi, 3'd2, 3'd0, 3'd0, 16'(next_random())));
        pad(3);
        prog.push_back(encode(core_pkg::op_add, 3'd3, 3'd1, 3'd0, 16'h0));
        prog.push_back(encode(core_pkg::op_or, 3'd4, 3'd2, 3'd0, 16'h0));
        // Undefined code, then words that must never be written
        prog.push_back(encode(4'(11 + next_random() % 5), 3'd5, 3'd1, 3'd2,
            16'(next_random())));
        prog.push_back(encode(core_pkg::op_ldi, 3'd5, 3'd0, 3'd0, 16'(next_random())));
        prog.push_back(encode(core_pkg::op_ldi, 3'd6, 3'd0, 3'd0, 16'(next_random())));
        prog.push_back(encode(core_pkg::op_addi, 3'd7, 3'd0, 3'd0, 16'(next_random())));
        prog.push_back(encode(core_pkg::op_stop, 3'd0, 3'd0, 3'd0, 16'h0));
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    task automatic model_run(input logic [2:0] n);
        int active;
        logic [31:0] w;
        logic [3:0] op;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm;
        logic [15:0] res;
        bit ended;
        bit writes;
        active = (n == 3'd0) ? 1 : int'(n);
        model_fault = 1'b0;
        for (int ch = 0; ch < active; ch++) begin
            ended = 1'b0;
            for (int pc = 0; pc < prog.size() && !ended; pc++) begin
                w = prog[pc];
                op = w[31:28];
                a = model_regs[ch][w[24:22]];
                b = model_regs[ch][w[21:19]];
                imm = w[15:0];
                res = 16'h0;
                writes = 1'b1;
                case (op)
                    core_pkg::op_add: res = a + b;
                    core_pkg::op_sub: res = a - b;
                    core_pkg::op_and: res = a & b;
                    core_pkg::op_or: res = a | b;
                    core_pkg::op_xor: res = a ^ b;
                    core_pkg::op_shl: res = a << imm[3:0];
                    core_pkg::op_addi: res = a + imm;
                    core_pkg::op_ldi: res = imm;
                    core_pkg::op_chan: res = 16'(ch);
                    core_pkg::op_nop: writes = 1'b0;
                    core_pkg::op_stop: begin
                        writes = 1'b0;
                        ended = 1'b1;
                    end
                    default: begin
                        writes = 1'b0;
                        ended = 1'b1;
                        model_fault = 1'b1;
                    end
                endcase
                if (writes) begin
                    model_regs[ch][w[27:25]] = res;
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // Host side sequences
    ////////////////////////////////////////

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clock);
            prog_write <= 1'b1;
            prog_addr <= 6'(i);
            prog_data <= prog[i];
        end
        @(posedge clock);
        prog_write <= 1'b0;
    endtask

    task automatic pulse_run(input logic [2:0] n);
        @(posedge clock);
        run <= 1'b1;
        n_channels <= n;
        @(posedge clock);
        run <= 1'b0;
    endtask

    task automatic wait_done(output logic fault_seen);
        @(negedge clock);
        while (!done) @(negedge clock);
        fault_seen = fault;
    endtask

    task automatic check_register(input logic [1:0] ch, input logic [2:0] r);
        @(posedge clock);
        host_read <= 1'b1;
        host_channel <= ch;
        host_addr <= r;
        @(posedge clock);
        host_read <= 1'b0;
        @(negedge clock);
        assert (host_data_valid)
            else report_mismatch($sformatf("no host_data_valid for channel %0d r%0d", ch, r));
        assert (host_data == model_regs[ch][r])
            else report_mismatch($sformatf("channel %0d r%0d read %h, expected %h",
                ch, r, host_data, model_regs[ch][r]));
    endtask

    task automatic check_all_registers();
        for (int c = 0; c < core_pkg::max_channels; c++) begin
            for (int r = 0; r < 8; r++) begin
                check_register(2'(c), 3'(r));
            end
        end
    endtask

    // Optionally strobes run again mid-run, which the core must ignore
    task automatic run_program(input logic [2:0] n, input bit poke_while_busy);
        logic fault_seen;
        load_program();
        pulse_run(n);
        runs_started++;
        model_run(n);
        @(negedge clock);
        assert (!fault) else report_mismatch("fault not cleared by an accepted run");
        if (poke_while_busy) begin
            repeat (2) @(negedge clock);
            assert (busy) else report_mismatch("busy low in the middle of a run");
            pulse_run(3'd4);
        end
        wait_done(fault_seen);
        assert (fault_seen == model_fault)
            else report_mismatch($sformatf("fault %b at done, expected %b",
                fault_seen, model_fault));
        if (poke_while_busy) begin
            repeat (run_cycles) @(negedge clock);
        end
        check_all_registers();
        assert (done_pulses == runs_started)
            else report_mismatch($sformatf("%0d done pulses for %0d runs",
                done_pulses, runs_started));
        assert (fault == model_fault)
            else report_mismatch("fault did not hold its value after done");
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        prog_write = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        run = 1'b0;
        n_channels = 3'd0;
        host_read = 1'b0;
        host_channel = '0;
        host_addr = '0;
        rng_state = 32'hbdf7_5929;
        runs_started = 0;
        done_pulses = 0;
        model_fault = 1'b0;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 8; r++) begin
                model_regs[c][r] = 16'h0;
            end
        end

        wait (arst_n === 1'b1);
        @(negedge clock);
        assert (!busy && !done && !fault && !host_data_valid)
            else report_mismatch("outputs not low after reset");
        check_all_registers();

        // Every ALU opcode on one channel
        for (int i = 0; i < 3; i++) begin
            build_alu_program();
            run_program(3'd1, 1'b0);
        end

        // All four channels first, so inactive banks hold values later on
        for (int i = 0; i < 5; i++) begin
            build_channel_program();
            run_program((i == 0) ? 3'd4 : 3'(1 + next_random() % 4), 1'b0);
        end

        // Zero channels runs as one, with a run strobe while busy
        build_channel_program();
        run_program(3'd0, 1'b1);

        // Illegal opcode, then a clean run that clears fault
        build_fault_program();
        run_program(3'(1 + next_random() % 4), 1'b0);
        build_channel_program();
        run_program(3'd2, 1'b0);

        $display("** PASS **");
        $finish;
    end

endmodule

/* channel_core.f */
src/core_pkg.sv
src/core_if.sv
src/instruction_store.sv
src/control_unit.sv
src/instruction_decoder.sv
src/register_file.sv
src/execution_unit.sv
src/channel_core.sv
testbench/clock_gen.sv
testbench/channel_core_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module channel_core_tb \
    -f channel_core.f -o channel_core_sim &&
./obj_dir/channel_core_sim || exit 1
